/* Makefile */
# Verilator flow for the vector stream testbench

VERILATOR ?= verilator
TOP       ?= tb_vector_stream
LOG       ?= sim.log
FLAGS     ?= --timing
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f files.f --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f files.f --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
rtl/stream_pkg.sv
rtl/lane_fifo.sv
rtl/stream_ingress.sv
rtl/vector_column.sv
rtl/stream_egress.sv
rtl/vector_stream_top.sv
test/tb_vector_stream.sv

/* rtl/lane_fifo.sv */
`timescale 1ns/1ps

module lane_fifo #(
    parameter int WIDTH = 34,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic [WIDTH-1:0] i_din,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_empty,
    output logic             o_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == CW'(DEPTH));
    assign do_push = i_push && !o_full;  // push on full is dropped
    assign do_pop  = i_pop && !o_empty;
    assign o_dout  = mem[rd_ptr];        // fall-through head

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/stream_egress.sv */
`timescale 1ns/1ps

module stream_egress import stream_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  beat_t                          i_beat,
    output logic                           o_advance,
    output logic [PHIT_W-1:0]              o_tdata,
    output logic                           o_tvalid,
    output logic [LANES*KEEP_PER_LANE-1:0] o_tkeep,
    output logic                           o_tlast,
    input  logic                           i_tready,
    output logic                           o_ap_done
);

    lane_entry_t      wr_entry [LANES];
    lane_entry_t      head     [LANES];
    logic [LANES-1:0] lane_full;
    logic [LANES-1:0] lane_empty;
    logic [LANES-1:0] head_last;
    logic             push;
    logic             pop;

    // global stall level for ingress and every column
    assign o_advance = !(|lane_full);

    // a beat with any kept lane is written across all lanes, keeping the lane valid bits
    assign push     = o_advance && (|i_beat.valid);
    assign o_tvalid = !(|lane_empty);
    assign pop      = o_tvalid && i_tready;
    assign o_tlast  = o_tvalid && (&head_last);

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        assign wr_entry[k].last  = i_beat.last;
        assign wr_entry[k].valid = i_beat.valid[k];
        assign wr_entry[k].data  = i_beat.data[k];

        lane_fifo #(
            .WIDTH ($bits(lane_entry_t)),
            .DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_push  (push),
            .i_pop   (pop),
            .i_din   (wr_entry[k]),
            .o_dout  (head[k]),
            .o_empty (lane_empty[k]),
            .o_full  (lane_full[k])
        );

        assign head_last[k]                              = head[k].last;
        assign o_tdata[k*LANE_W +: LANE_W]               = head[k].data;
        assign o_tkeep[k*KEEP_PER_LANE +: KEEP_PER_LANE] = {KEEP_PER_LANE{head[k].valid}};
    end

    // done pulse one cycle after the last transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            o_ap_done <= 1'b0;
        end else begin
            o_ap_done <= pop && o_tlast;
        end
    end

endmodule

/* rtl/stream_ingress.sv */
`timescale 1ns/1ps

module stream_ingress import stream_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [PHIT_W-1:0]              i_tdata,
    input  logic                           i_tvalid,
    input  logic [LANES*KEEP_PER_LANE-1:0] i_tkeep,
    input  logic                           i_tlast,
    output logic                           o_tready,
    input  logic                           i_done_loader,
    input  logic                           i_advance,
    output beat_t                          o_beat,
    output logic                           o_done_steady
);

    typedef enum logic {
        ST_IDLE   = 1'b0,
        ST_STEADY = 1'b1
    } steady_e;

    steady_e          state;
    steady_e          state_nxt;
    lane_entry_t      wr_entry [LANES];
    lane_entry_t      head     [LANES];
    logic [LANES-1:0] lane_full;
    logic [LANES-1:0] lane_empty;
    logic [LANES-1:0] head_last;
    logic             push;
    logic             pop;

    assign o_done_steady = (state == ST_STEADY);
    assign o_tready      = o_done_steady && !(|lane_full);
    assign push          = i_tvalid && o_tready;
    assign pop           = i_advance && !(|lane_empty); // all lanes leave together

    // steady flag, set by the loader and cleared by the last beat of a packet
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:   state_nxt = i_done_loader ? ST_STEADY : ST_IDLE;
            ST_STEADY: state_nxt = (pop && (&head_last)) ? ST_IDLE : ST_STEADY;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        assign wr_entry[k].last  = i_tlast;
        assign wr_entry[k].valid = i_tvalid && (&i_tkeep[k*KEEP_PER_LANE +: KEEP_PER_LANE]);
        assign wr_entry[k].data  = i_tdata[k*LANE_W +: LANE_W];

        lane_fifo #(
            .WIDTH ($bits(lane_entry_t)),
            .DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_push  (push),
            .i_pop   (pop),
            .i_din   (wr_entry[k]),
            .o_dout  (head[k]),
            .o_empty (lane_empty[k]),
            .o_full  (lane_full[k])
        );

        assign head_last[k]      = head[k].last;
        assign o_beat.valid[k]   = pop && head[k].valid; // only in the pop cycle
        assign o_beat.data[k]    = head[k].data;
    end

    assign o_beat.last = pop && (&head_last);

endmodule

/* rtl/stream_pkg.sv */
package stream_pkg;

    // lane geometry
    localparam int LANE_W        = 32;
    localparam int LANES         = 4;
    localparam int PHIT_W        = LANES * LANE_W;
    localparam int KEEP_PER_LANE = 4; // byte strobes per lane word
    localparam int LANE_IDX_W    = $clog2(LANES);

    // column addressing
    localparam int MAX_COLS  = 8;
    localparam int COL_IDX_W = $clog2(MAX_COLS);

    // per-column vector register file
    localparam int VRF_DEPTH  = 16;
    localparam int VRF_ADDR_W = $clog2(VRF_DEPTH);

    typedef logic [LANE_W-1:0] lane_t;

    // one beat between datapath blocks
    typedef struct packed {
        logic [LANES-1:0] valid; // per lane, from tkeep
        logic             last;
        lane_t [LANES-1:0] data;
    } beat_t;

    // one lane word as stored in the lane FIFOs
    typedef struct packed {
        logic  last;
        logic  valid;
        lane_t data;
    } lane_entry_t;

    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_MUL  = 2'd2, // low 32 bits of the product
        OP_MAC  = 2'd3
    } col_op_e;

    typedef enum logic {
        CFG_OP     = 1'b0,
        CFG_WEIGHT = 1'b1
    } cfg_kind_e;

    // configuration word, decoded by kind
    typedef struct packed {
        cfg_kind_e               kind;
        logic [COL_IDX_W-1:0]    col;
        logic [VRF_ADDR_W-1:0]   addr;  // weight entry
        logic [LANE_IDX_W-1:0]   lane;  // weight lane
        col_op_e                 op;
        logic [VRF_ADDR_W-1:0]   vlen;  // pointer wraps after vlen entries
        lane_t                   value; // weight value
    } cfg_t;

endpackage

/* rtl/vector_column.sv */
`timescale 1ns/1ps

module vector_column import stream_pkg::*; #(
    parameter int COL_ID = 0
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_cfg_valid,
    input  cfg_t  i_cfg,
    input  logic  i_advance,
    input  beat_t i_beat,
    output beat_t o_beat
);

    lane_t [LANES-1:0]     vrf [VRF_DEPTH]; // one weight word per lane per entry
    col_op_e               op;
    logic [VRF_ADDR_W-1:0] vlen;
    logic [VRF_ADDR_W-1:0] rd_ptr;
    logic [VRF_ADDR_W-1:0] ptr_nxt;
    logic [VRF_ADDR_W:0]   ptr_inc;
    lane_t [LANES-1:0]     weight;
    lane_t [LANES-1:0]     prod;
    lane_t [LANES-1:0]     acc;
    lane_t [LANES-1:0]     acc_nxt;
    lane_t [LANES-1:0]     res;
    logic                  cfg_hit;
    logic                  any_valid;

    assign cfg_hit   = i_cfg_valid && (i_cfg.col == COL_IDX_W'(COL_ID));
    assign any_valid = |i_beat.valid;
    assign weight    = vrf[rd_ptr];

    // read pointer runs 0 .. vlen-1
    assign ptr_inc = {1'b0, rd_ptr} + 1'b1;
    assign ptr_nxt = (ptr_inc >= {1'b0, vlen}) ? '0 : ptr_inc[VRF_ADDR_W-1:0];

    always_comb begin
        res     = i_beat.data; // invalid lanes pass through
        acc_nxt = acc;
        for (int k = 0; k < LANES; k++) begin
            prod[k] = i_beat.data[k] * weight[k]; // keeps the low word
            if (i_beat.valid[k]) begin
                case (op)
                    OP_ADD: res[k] = i_beat.data[k] + weight[k];
                    OP_MUL: res[k] = prod[k];
                    OP_MAC: begin
                        acc_nxt[k] = acc[k] + prod[k];
                        res[k]     = acc_nxt[k];
                    end
                    default: res[k] = i_beat.data[k];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_hit && i_cfg.kind == CFG_WEIGHT) begin
            vrf[i_cfg.addr][i_cfg.lane] <= i_cfg.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op     <= OP_PASS;
            vlen   <= '0;
            rd_ptr <= '0;
            acc    <= '0;
        end else if (cfg_hit && i_cfg.kind == CFG_OP) begin
            op     <= i_cfg.op;
            vlen   <= i_cfg.vlen;
            rd_ptr <= '0; // new op starts a fresh vector
            acc    <= '0;
        end else if (i_advance && any_valid) begin
            if (i_beat.last) begin
                rd_ptr <= '0;
                acc    <= '0;
            end else begin
                rd_ptr <= ptr_nxt;
                acc    <= acc_nxt;
            end
        end
    end

    // output beat, held while the chain is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            o_beat.valid <= '0;
            o_beat.last  <= 1'b0;
        end else if (i_advance) begin
            o_beat.valid <= i_beat.valid;
            o_beat.last  <= i_beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            o_beat.data <= res;
        end
    end

endmodule

/* rtl/vector_stream_top.sv */
`timescale 1ns/1ps

module vector_stream_top import stream_pkg::*; #(
    parameter int NUM_COL    = 3,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_done_loader,
    // configuration strobe
    input  logic                           i_cfg_valid,
    input  cfg_t                           i_cfg,
    // input stream
    input  logic [PHIT_W-1:0]              i_tdata,
    input  logic                           i_tvalid,
    input  logic [LANES*KEEP_PER_LANE-1:0] i_tkeep,
    input  logic                           i_tlast,
    output logic                           o_tready,
    // output stream
    output logic [PHIT_W-1:0]              o_tdata,
    output logic                           o_tvalid,
    output logic [LANES*KEEP_PER_LANE-1:0] o_tkeep,
    output logic                           o_tlast,
    input  logic                           i_tready,
    output logic                           o_done_steady,
    output logic                           o_ap_done
);

    beat_t chain [NUM_COL+1]; // chain[c] feeds column c
    logic  advance;

    stream_ingress #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ingress (
        .clk           (clk),
        .rst           (rst),
        .i_tdata       (i_tdata),
        .i_tvalid      (i_tvalid),
        .i_tkeep       (i_tkeep),
        .i_tlast       (i_tlast),
        .o_tready      (o_tready),
        .i_done_loader (i_done_loader),
        .i_advance     (advance),
        .o_beat        (chain[0]),
        .o_done_steady (o_done_steady)
    );

    for (genvar c = 0; c < NUM_COL; c++) begin : g_col
        vector_column #(
            .COL_ID (c)
        ) u_column (
            .clk         (clk),
            .rst         (rst),
            .i_cfg_valid (i_cfg_valid),
            .i_cfg       (i_cfg),
            .i_advance   (advance),
            .i_beat      (chain[c]),
            .o_beat      (chain[c+1])
        );
    end

    stream_egress #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_egress (
        .clk       (clk),
        .rst       (rst),
        .i_beat    (chain[NUM_COL]),
        .o_advance (advance),
        .o_tdata   (o_tdata),
        .o_tvalid  (o_tvalid),
        .o_tkeep   (o_tkeep),
        .o_tlast   (o_tlast),
        .i_tready  (i_tready),
        .o_ap_done (o_ap_done)
    );

endmodule

/* test/stream_input.txt */
# C kind col addr lane op vlen weight | D loader done | B lane0 lane1 lane2 lane3 tkeep last
# all fields hex, kind 0 op 1 weight, op 0 pass 1 add 2 mul 3 mac
D
B 00000001 00000002 00000003 00000004 ffff 0
B 11111111 22222222 33333333 44444444 ffff 0
B deadbeef 0badf00d 12345678 9abcdef0 ffff 1
C 1 0 0 0 0 0 00000010
C 1 0 0 1 0 0 00000020
C 1 0 0 2 0 0 00000030
C 1 0 0 3 0 0 00000040
C 1 0 1 0 0 0 00000100
C 1 0 1 1 0 0 00000200
C 1 0 1 2 0 0 00000300
C 1 0 1 3 0 0 00000400
C 0 0 0 0 1 2 00000000
C 1 1 0 0 0 0 00000003
C 1 1 0 1 0 0 00000005
C 1 1 0 2 0 0 fffffffe
C 1 1 0 3 0 0 00010001
C 0 1 0 0 2 1 00000000
C 1 2 0 0 0 0 00000002
C 1 2 0 1 0 0 00000007
C 1 2 0 2 0 0 00000001
C 1 2 0 3 0 0 80000001
C 0 2 0 0 3 1 00000000
D
B 00000001 00000002 00000003 00000004 ffff 0
B 00000005 00000006 00000007 00000008 f3ff 0
B 00000009 0000000a 0000000b 0000000c ffff 0
B 7fffffff 80000000 ffffffff 00001234 ffff 0
B 00000010 00000020 00000030 00000040 ffff 1
D
B 00000002 00000003 00000004 00000005 0fff 0
B 00000006 00000007 00000008 00000009 ffff 1

/* test/tb_vector_stream.sv */
`timescale 1ns/1ps

module tb_vector_stream import stream_pkg::*; ();

    localparam int NUM_COL    = 3;
    localparam int FIFO_DEPTH = 2;    // shallow, so output stalls reach the columns and ingress
    localparam int TIMEOUT    = 2000; // cycles allowed per wait
    localparam int KEEP_W     = LANES * KEEP_PER_LANE;

    // one expected output transfer
    typedef struct packed {
        logic [PHIT_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } out_beat_t;

    logic              clk;
    logic              rst;
    logic              i_done_loader;
    logic              i_cfg_valid;
    cfg_t              i_cfg;
    logic [PHIT_W-1:0] i_tdata;
    logic              i_tvalid;
    logic [KEEP_W-1:0] i_tkeep;
    logic              i_tlast;
    logic              o_tready;
    logic [PHIT_W-1:0] o_tdata;
    logic              o_tvalid;
    logic [KEEP_W-1:0] o_tkeep;
    logic              o_tlast;
    logic              i_tready;
    logic              o_done_steady;
    logic              o_ap_done;

    // reference model state, one set per column
    lane_t   m_weight [NUM_COL][VRF_DEPTH][LANES];
    col_op_e m_op     [NUM_COL];
    int      m_vlen   [NUM_COL];
    int      m_ptr    [NUM_COL];
    lane_t   m_acc    [NUM_COL][LANES];

    out_beat_t exp_q [$];
    int        packets_sent;
    int        done_pulses;
    int        rnd;
    integer    seed = 32'hff79_6c9d;

    vector_stream_top #(
        .NUM_COL    (NUM_COL),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .i_done_loader (i_done_loader),
        .i_cfg_valid   (i_cfg_valid),
        .i_cfg         (i_cfg),
        .i_tdata       (i_tdata),
        .i_tvalid      (i_tvalid),
        .i_tkeep       (i_tkeep),
        .i_tlast       (i_tlast),
        .o_tready      (o_tready),
        .o_tdata       (o_tdata),
        .o_tvalid      (o_tvalid),
        .o_tkeep       (o_tkeep),
        .o_tlast       (o_tlast),
        .i_tready      (i_tready),
        .o_done_steady (o_done_steady),
        .o_ap_done     (o_ap_done)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [PHIT_W-1:0] got, input logic [PHIT_W-1:0] exp,
                         input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s got %0h expected %0h",
                                $time, what, got, exp));
        end
    endtask

    task automatic wait_steady(input logic level);
        int cycles;
        cycles = 0;
        while (o_done_steady !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("timeout waiting for o_done_steady to become %0b", level));
            end
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timeout waiting for the expected output beats to leave");
            end
        end
    endtask

    task automatic pulse_loader();
        wait_steady(1'b0); // last packet must have left ingress
        i_done_loader = 1'b1;
        @(posedge clk);
        #1;
        i_done_loader = 1'b0;
        wait_steady(1'b1);
    endtask

    task automatic write_cfg(input cfg_t cfg);
        int col;
        col = int'(cfg.col);
        if (col >= NUM_COL) begin
            abort_run("configuration record names a column that does not exist");
        end
        wait_drained(); // ops only change between packets
        if (cfg.kind == CFG_WEIGHT) begin
            m_weight[col][int'(cfg.addr)][int'(cfg.lane)] = cfg.value;
        end else begin
            m_op[col]   = cfg.op;
            m_vlen[col] = int'(cfg.vlen);
            m_ptr[col]  = 0;
            for (int k = 0; k < LANES; k++) begin
                m_acc[col][k] = '0;
            end
        end
        i_cfg       = cfg;
        i_cfg_valid = 1'b1;
        @(posedge clk);
        #1;
        i_cfg_valid = 1'b0;
    endtask

    // expected beat after all columns, queued in input order
    task automatic predict_beat(input logic [PHIT_W-1:0] data, input logic [KEEP_W-1:0] keep,
                                input logic last);
        lane_t            val [LANES];
        logic [LANES-1:0] kept;
        lane_t            w;
        out_beat_t        want;
        for (int k = 0; k < LANES; k++) begin
            val[k]  = data[k*LANE_W +: LANE_W];
            kept[k] = &keep[k*KEEP_PER_LANE +: KEEP_PER_LANE];
        end
        if (kept == '0) begin
            abort_run("stimulus beat has no lane with full tkeep");
        end
        for (int c = 0; c < NUM_COL; c++) begin
            for (int k = 0; k < LANES; k++) begin
                w = m_weight[c][m_ptr[c]][k];
                if (kept[k]) begin
                    case (m_op[c])
                        OP_ADD: val[k] = val[k] + w;
                        OP_MUL: val[k] = val[k] * w;
                        OP_MAC: begin
                            m_acc[c][k] = m_acc[c][k] + val[k] * w;
                            val[k]      = m_acc[c][k];
                        end
                        default: val[k] = val[k];
                    endcase
                end
            end
            if (last) begin
                m_ptr[c] = 0; // packet end restarts the vector
                for (int k = 0; k < LANES; k++) begin
                    m_acc[c][k] = '0;
                end
            end else begin
                m_ptr[c] = (m_ptr[c] + 1 >= m_vlen[c]) ? 0 : m_ptr[c] + 1;
            end
        end
        for (int k = 0; k < LANES; k++) begin
            want.data[k*LANE_W +: LANE_W]               = val[k];
            want.keep[k*KEEP_PER_LANE +: KEEP_PER_LANE] = {KEEP_PER_LANE{kept[k]}};
        end
        want.last = last;
        exp_q.push_back(want);
    endtask

    task automatic send_beat(input logic [PHIT_W-1:0] data, input logic [KEEP_W-1:0] keep,
                             input logic last);
        int   cycles;
        logic taken;
        cycles = 0;
        taken  = 1'b0;
        predict_beat(data, keep, last);
        i_tdata  = data;
        i_tkeep  = keep;
        i_tlast  = last;
        i_tvalid = 1'b1;
        while (!taken) begin
            taken = o_tready; // stable until the next edge
            @(posedge clk);
            #1;
            cycles++;
            if (!taken && cycles > TIMEOUT) begin
                abort_run("timeout waiting for o_tready on an input beat");
            end
        end
        i_tvalid = 1'b0;
        if (last) begin
            packets_sent++;
        end
    endtask

    // output back-pressure
    always @(posedge clk) begin
        #1;
        rnd      = $random(seed);
        i_tready = rnd[0];
    end

    // output side, sampled half a cycle before the transfer edge
    always @(negedge clk) begin : monitor
        out_beat_t want;
        if (!rst) begin
            if (o_ap_done) begin
                done_pulses++;
            end
            if (o_tvalid && i_tready) begin
                if (exp_q.size() == 0) begin
                    abort_run("output beat appeared with no beat expected");
                end else begin
                    want = exp_q.pop_front();
                    check(o_tdata, want.data, "o_tdata");
                    check(PHIT_W'(o_tkeep), PHIT_W'(want.keep), "o_tkeep");
                    check(PHIT_W'(o_tlast), PHIT_W'(want.last), "o_tlast");
                end
            end
        end
    end

    initial begin
        int               fd;
        int               code;
        int               cycles;
        logic [7:0]       rec;
        logic [8*160-1:0] line;
        logic [31:0]      f [7];
        cfg_t             cfg;
        clk           = 1'b0;
        rst           = 1'b1;
        i_done_loader = 1'b0;
        i_cfg_valid   = 1'b0;
        i_cfg         = '0;
        i_tdata       = '0;
        i_tvalid      = 1'b0;
        i_tkeep       = '0;
        i_tlast       = 1'b0;
        i_tready      = 1'b0;
        packets_sent  = 0;
        done_pulses   = 0;
        for (int c = 0; c < NUM_COL; c++) begin
            m_op[c]   = OP_PASS;
            m_vlen[c] = 0;
            m_ptr[c]  = 0;
            for (int k = 0; k < LANES; k++) begin
                m_acc[c][k] = '0;
                for (int a = 0; a < VRF_DEPTH; a++) begin
                    m_weight[c][a][k] = '0;
                end
            end
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        // idle until the loader finishes
        check(PHIT_W'(o_tready), '0, "o_tready before loader done");
        check(PHIT_W'(o_tvalid), '0, "o_tvalid before loader done");
        check(PHIT_W'(o_done_steady), '0, "o_done_steady before loader done");

        fd = $fopen("test/stream_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/stream_input.txt");
        end
        while ($fscanf(fd, " %c", rec) == 1) begin
            case (rec)
                "#": code = $fgets(line, fd);
                "D": pulse_loader();
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    if (code != 7) begin
                        abort_run("malformed configuration record in stimulus file");
                    end
                    cfg.kind  = cfg_kind_e'(f[0][0]);
                    cfg.col   = f[1][COL_IDX_W-1:0];
                    cfg.addr  = f[2][VRF_ADDR_W-1:0];
                    cfg.lane  = f[3][LANE_IDX_W-1:0];
                    cfg.op    = col_op_e'(f[4][1:0]);
                    cfg.vlen  = f[5][VRF_ADDR_W-1:0];
                    cfg.value = f[6];
                    write_cfg(cfg);
                end
                "B": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                    if (code != 6) begin
                        abort_run("malformed beat record in stimulus file");
                    end
                    send_beat({f[3], f[2], f[1], f[0]}, f[4][KEEP_W-1:0], f[5][0]);
                end
                default: abort_run("unknown record type in stimulus file");
            endcase
        end
        $fclose(fd);

        wait_drained();
        cycles = 0;
        while (done_pulses < packets_sent) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timeout waiting for o_ap_done after the last beat");
            end
        end
        @(negedge clk); // a stretched pulse would count twice here
        #1;
        check(PHIT_W'(done_pulses), PHIT_W'(packets_sent), "o_ap_done pulse count");
        check(PHIT_W'(o_done_steady), '0, "o_done_steady after last beat");
        $display("Test passed");
        $finish;
    end

endmodule
